//--- verilog/channel_consts.svh
`ifndef CHANNEL_CONSTS_SVH
`define CHANNEL_CONSTS_SVH

// ------------------------------
// data path widths
// ------------------------------
`define DATA_W      8
`define ERR_CNT_W   8           // same width as the raw request field

// error count handling
`define ERR_LIMIT   8           // highest count taken as is
`define ERR_CLAMP   7           // replaces anything above the limit

// ------------------------------
// pseudo-random sources
// ------------------------------
`define LFSR_W      16
`define NOISE_SEED  16'hACE1
`define ERR_SEED    16'h5A3C

// x^16 + x^14 + x^13 + x^11 + 1, fibonacci form shifting left
`define LFSR_TAPS   16'hB400

`endif

//--- verilog/channel_pkg.sv
`include "channel_consts.svh"

package channel_pkg;

    // ------------------------------
    // payload types
    // ------------------------------
    typedef logic [`DATA_W-1:0]    data_t;
    typedef logic [`DATA_W-1:0]    density_t;    // one mask bit per data bit
    typedef logic [`ERR_CNT_W-1:0] err_count_t;
    typedef logic [`LFSR_W-1:0]    lfsr_t;

    // controller sequencing
    typedef enum logic [1:0] {
        st_idle,    // waiting for a request edge
        st_run,     // paths busy
        st_hold     // result presented
    } ctrl_state_t;

endpackage

//--- verilog/chan_req_if.sv
`timescale 1ns/100ps

// captured request, fanned out to both impairment paths
interface chan_req_if import channel_pkg::*; ();

    logic       start;       // one cycle launch pulse
    data_t      data;
    density_t   density;
    err_count_t err_count;   // already clamped
    logic       noise_en;
    logic       err_en;

    modport ctrl (
        output start, data, density, err_count, noise_en, err_en
    );

    modport path (
        input start, data, density, err_count, noise_en, err_en
    );

endinterface

//--- verilog/noise_gen.sv
`timescale 1ns/100ps
`include "channel_consts.svh"

module noise_gen import channel_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    chan_req_if.path req,
    output logic     noise_done,
    output data_t    noise_data
);

    lfsr_t lfsr;
    logic  feedback;
    logic  launch;

    assign feedback = ^(lfsr & `LFSR_TAPS);
    assign launch   = req.start && req.noise_en;    // start alone is not ours

    // ------------------------------
    // free-running noise source
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= `NOISE_SEED;
        end else begin
            lfsr <= {lfsr[`LFSR_W-2:0], feedback};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            noise_done <= 1'b0;
        end else begin
            noise_done <= launch;   // result lands one cycle after start
        end
    end

    // only bits set in density can be touched
    always_ff @(posedge clk) begin
        if (launch) begin
            noise_data <= req.data ^ (lfsr[`DATA_W-1:0] & req.density);
        end
    end

endmodule

//--- verilog/error_injector.sv
`timescale 1ns/100ps
`include "channel_consts.svh"

module error_injector import channel_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    chan_req_if.path req,
    output logic     err_done,
    output data_t    err_data
);

    localparam int IDX_W = $clog2(`DATA_W);

    lfsr_t            lfsr;
    logic             feedback;
    logic             launch;
    logic             busy;
    data_t            flip_mask;     // bits already flipped
    err_count_t       flips;
    err_count_t       flips_next;
    logic [IDX_W-1:0] bit_idx;
    logic             do_flip;
    logic             last_flip;

    assign feedback   = ^(lfsr & `LFSR_TAPS);
    assign launch     = req.start && req.err_en;
    assign bit_idx    = lfsr[IDX_W-1:0];
    assign do_flip    = busy && !flip_mask[bit_idx];    // skip repeated indices
    assign flips_next = flips + 1'b1;

    // a request of zero still costs one flip
    assign last_flip = (flips_next == req.err_count) || (req.err_count == '0);

    // ------------------------------
    // bit index source
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= `ERR_SEED;
        end else begin
            lfsr <= {lfsr[`LFSR_W-2:0], feedback};
        end
    end

    // ------------------------------
    // flip sequencing
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            err_done  <= 1'b0;
            flip_mask <= '0;
            flips     <= '0;
        end else begin
            err_done <= 1'b0;
            if (launch) begin
                busy      <= 1'b1;
                flip_mask <= '0;
                flips     <= '0;
            end else if (do_flip) begin
                flip_mask[bit_idx] <= 1'b1;
                flips              <= flips_next;
                if (last_flip) begin
                    busy     <= 1'b0;
                    err_done <= 1'b1;
                end
            end
        end
    end

    // working byte, holds once busy drops
    always_ff @(posedge clk) begin
        if (launch) begin
            err_data <= req.data;
        end else if (do_flip) begin
            err_data[bit_idx] <= ~err_data[bit_idx];
        end
    end

endmodule

//--- verilog/channel_ctrl.sv
`timescale 1ns/100ps
`include "channel_consts.svh"

module channel_ctrl import channel_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  data_t      data_in,
    input  logic       noise_en,
    input  logic       err_en,
    input  logic       data_valid,
    input  density_t   density,
    input  err_count_t err_count,
    chan_req_if.ctrl   req,
    input  logic       noise_done,
    input  logic       err_done,
    input  data_t      noise_data,
    input  data_t      err_data,
    output data_t      data_out,
    output logic       out_ready
);

    ctrl_state_t state;
    logic        valid_q;
    logic        valid_rise;
    logic        capture;
    logic        noise_fin;      // path finished or not needed
    logic        err_fin;
    err_count_t  count_clamped;

    // ------------------------------
    // request edge and count clamp
    // ------------------------------
    assign valid_rise = data_valid && !valid_q;

    // a held result counts as idle
    // edges that arrive during a run are dropped
    assign capture = valid_rise && ((state == st_idle) || (state == st_hold));

    assign count_clamped = (err_count > err_count_t'(`ERR_LIMIT)) ?
                           err_count_t'(`ERR_CLAMP) : err_count;

    // ------------------------------
    // sequencing and output register
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= st_idle;
            valid_q      <= 1'b0;
            req.start    <= 1'b0;
            req.noise_en <= 1'b0;
            req.err_en   <= 1'b0;
            noise_fin    <= 1'b0;
            err_fin      <= 1'b0;
            out_ready    <= 1'b0;
            data_out     <= '0;
        end else begin
            valid_q   <= data_valid;
            req.start <= capture;      // launch one cycle after capture
            if (capture) begin
                state        <= st_idle;
                out_ready    <= 1'b0;
                req.noise_en <= noise_en;
                req.err_en   <= err_en;
                noise_fin    <= !noise_en;
                err_fin      <= !err_en;
            end else begin
                case (state)
                    st_idle: begin
                        if (req.start) begin
                            state <= st_run;
                        end
                    end
                    st_run: begin
                        if (noise_done) begin
                            noise_fin <= 1'b1;
                        end
                        if (err_done) begin
                            err_fin <= 1'b1;
                        end
                        if (noise_fin && err_fin) begin
                            // errors win over noise, noise over raw data
                            if (req.err_en) begin
                                data_out <= err_data;
                            end else if (req.noise_en) begin
                                data_out <= noise_data;
                            end else begin
                                data_out <= req.data;
                            end
                            out_ready <= 1'b1;
                            state     <= st_hold;
                        end
                    end
                    default: begin
                        state <= st_hold;    // wait for next edge
                    end
                endcase
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (capture) begin
            req.data      <= data_in;
            req.density   <= density;
            req.err_count <= count_clamped;
        end
    end

endmodule

//--- verilog/channel_sim.sv
`timescale 1ns/100ps

module channel_sim import channel_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  data_t      data_in,
    input  logic       noise_en,
    input  logic       err_en,
    input  density_t   density,
    input  err_count_t err_count,
    input  logic       data_valid,
    output data_t      data_out,
    output logic       out_ready
);

    logic  noise_done;
    logic  err_done;
    data_t noise_data;
    data_t err_data;

    chan_req_if req_if ();

    // ------------------------------
    // request capture and output
    // ------------------------------
    channel_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .data_in    (data_in),
        .noise_en   (noise_en),
        .err_en     (err_en),
        .data_valid (data_valid),
        .density    (density),
        .err_count  (err_count),
        .req        (req_if.ctrl),
        .noise_done (noise_done),
        .err_done   (err_done),
        .noise_data (noise_data),
        .err_data   (err_data),
        .data_out   (data_out),
        .out_ready  (out_ready)
    );

    // ------------------------------
    // impairment paths
    // ------------------------------
    noise_gen noise_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req_if.path),
        .noise_done (noise_done),
        .noise_data (noise_data)
    );

    error_injector err_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req_if.path),
        .err_done (err_done),
        .err_data (err_data)
    );

endmodule

//--- dv/channel_sim_props.sv
`timescale 1ns/100ps

module channel_sim_props import channel_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        out_ready,
    input data_t       data_out,
    input logic        start,
    input ctrl_state_t state
);

    // ------------------------------
    // output side
    // ------------------------------
    ready_low_in_reset: assert property (@(posedge clk) rst |-> !out_ready)
        else $error("out_ready high while rst is asserted");

    out_stable: assert property (@(posedge clk) disable iff (rst)
        (out_ready && $past(out_ready)) |-> $stable(data_out))
        else $error("data_out changed while out_ready stayed high");

    // launch pulse
    start_single: assert property (@(posedge clk) disable iff (rst) start |=> !start)
        else $error("start held for more than one cycle");

    start_in_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> (state == st_idle))
        else $error("start seen outside st_idle");

endmodule

bind channel_ctrl channel_sim_props props_i (
    .clk       (clk),
    .rst       (rst),
    .out_ready (out_ready),
    .data_out  (data_out),
    .start     (req.start),
    .state     (state)
);

//--- dv/channel_sim_tb.sv
`timescale 1ns/100ps

module channel_sim_tb import channel_pkg::*;;

    localparam int DRIVE_DLY = 1;      // ns after the rising edge

    logic       clk;
    logic       rst;
    data_t      data_in;
    logic       noise_en;
    logic       err_en;
    density_t   density;
    err_count_t err_count;
    logic       data_valid;
    data_t      data_out;
    logic       out_ready;

    // requests from the input file
    logic [7:0] req_data[$];
    logic       req_noise[$];
    logic       req_err[$];
    logic [7:0] req_density[$];
    logic [7:0] req_count[$];

    int     checks;
    int     errors;
    int     cycle_limit;
    integer seed;
    logic   last_ready;    // what the output should still hold
    data_t  last_out;

    channel_sim dut_i (
        .clk        (clk),
        .rst        (rst),
        .data_in    (data_in),
        .noise_en   (noise_en),
        .err_en     (err_en),
        .density    (density),
        .err_count  (err_count),
        .data_valid (data_valid),
        .data_out   (data_out),
        .out_ready  (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic int count_ones(input data_t v);
        int n;
        n = 0;
        for (int b = 0; b < 8; b++) begin
            n += int'(v[b]);
        end
        return n;
    endfunction

    // zero still flips one bit, counts above 8 clamp to 7
    function automatic int expected_flips(input logic [7:0] c);
        if (c == 8'd0) begin
            return 1;
        end else if (c > 8'd8) begin
            return 7;
        end
        return int'(c);
    endfunction

    task automatic load_requests();
        int         fd;
        string      line;
        logic [7:0] f_data;
        logic [7:0] f_nen;
        logic [7:0] f_een;
        logic [7:0] f_den;
        logic [7:0] f_cnt;
        fd = $fopen("dv/channel_input.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/channel_input.txt");
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h %h %h", f_data, f_nen, f_een, f_den, f_cnt) == 5) begin
                    req_data.push_back(f_data);
                    req_noise.push_back(f_nen[0]);
                    req_err.push_back(f_een[0]);
                    req_density.push_back(f_den);
                    req_count.push_back(f_cnt);
                end
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------
    // one request, entered just after a drive point
    // ------------------------------
    task automatic run_request(input int idx);
        data_t d;
        int    gap;
        int    lat;
        int    flips;
        logic  intrude;
        logic  ready_seen;
        d       = req_data[idx];
        flips   = expected_flips(req_count[idx]);
        intrude = req_err[idx] && (flips >= 7);    // long enough for a stray edge
        gap     = 1 + ({$random(seed)} % 8);
        repeat (gap) begin
            @(negedge clk);
            check_value("out_ready held between requests", int'(out_ready), int'(last_ready));
            check_value("data_out held between requests", int'(data_out), int'(last_out));
            @(posedge clk);
            #DRIVE_DLY;
        end
        data_in    = d;
        noise_en   = req_noise[idx];
        err_en     = req_err[idx];
        density    = req_density[idx];
        err_count  = req_count[idx];
        data_valid = 1'b1;
        @(posedge clk);                  // capture edge
        #DRIVE_DLY;
        if (intrude) begin
            data_valid = 1'b0;
        end
        @(negedge clk);
        check_value("out_ready low after capture", int'(out_ready), 0);
        lat        = 0;
        ready_seen = 1'b0;
        while (!ready_seen) begin
            @(posedge clk);
            lat++;
            if (intrude && lat == 1) begin
                #DRIVE_DLY;
                data_in    = ~d;         // must never reach the output
                data_valid = 1'b1;
            end
            @(negedge clk);
            ready_seen = out_ready;
        end
        if (req_err[idx]) begin
            check_value("flipped bits of error request", count_ones(data_out ^ d), flips);
            check_value("error latency covers the flips", int'(lat > flips), 1);
        end else if (req_noise[idx]) begin
            check_value("noise outside density mask",
                        int'((data_out ^ d) & ~req_density[idx]), 0);
            check_value("noise latency", lat, 3);
        end else begin
            check_value("pass-through data", int'(data_out), int'(d));
            check_value("pass-through latency", lat, 2);
        end
        last_ready = 1'b1;
        last_out   = data_out;
        @(posedge clk);
        #DRIVE_DLY;
        data_valid = 1'b0;
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin : stimulus
        rst         = 1'b1;
        data_in     = '0;
        noise_en    = 1'b0;
        err_en      = 1'b0;
        density     = '0;
        err_count   = '0;
        data_valid  = 1'b0;
        checks      = 0;
        errors      = 0;
        cycle_limit = 0;
        seed        = 40137;
        last_ready  = 1'b0;              // reset values
        last_out    = '0;
        load_requests();
        if (req_data.size() == 0) begin
            $display("no requests were read from dv/channel_input.txt");
            errors++;
        end
        cycle_limit = req_data.size() * 600;
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        for (int i = 0; i < req_data.size(); i++) begin
            run_request(i);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the design never raised out_ready", cycles);
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- dv/channel_input.txt
# columns, all hex: data noise_en err_en density err_count
# output follows from the mode bits, the density mask and the count rule
A5 0 0 00 00
3C 0 0 FF 05
5A 1 0 0F 00
C3 1 0 F0 00
FF 1 0 00 00
00 1 0 FF 00
96 0 1 00 00
69 0 1 00 03
0F 0 1 00 08
F0 0 1 00 09
55 0 1 00 C8
AA 1 1 FF 03
12 1 1 0F 00
34 1 1 FF C8
E7 0 1 00 08
81 0 0 00 00

//--- channel_sim.f
+incdir+verilog
verilog/channel_pkg.sv
verilog/chan_req_if.sv
verilog/noise_gen.sv
verilog/error_injector.sv
verilog/channel_ctrl.sv
verilog/channel_sim.sv
dv/channel_sim_props.sv
dv/channel_sim_tb.sv

//--- Makefile
TOP = channel_sim_tb
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --top-module $(TOP) -f channel_sim.f -o sim
	./obj_dir/sim | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG) || ! grep -q "Done: no errors" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --top-module $(TOP) -f channel_sim.f

clean:
	rm -rf obj_dir $(LOG)
